// File: design/fpu_classify.sv
// ==============================
// Single-precision class decoder
// Class facts and the one-hot FCLASS mask
// ==============================

`timescale 1ns/1ns

module fpu_classify import fpu_pkg::*; (
  input  logic [FLEN-1:0]    value,
  output logic               sign,
  output logic               is_zero,
  output logic               is_sub,
  output logic               is_norm,
  output logic               is_inf,
  output logic               is_nan,
  output logic               is_snan,
  output logic [CLASS_W-1:0] class_mask
);

  logic [EXP_W-1:0] exp_f;
  logic [MAN_W-1:0] man_f;
  logic             exp_ones;
  logic             exp_zero;
  logic             man_zero;

  assign sign  = value[SIGN_BIT];
  assign exp_f = value[SIGN_BIT-1 -: EXP_W];
  assign man_f = value[MAN_W-1:0];

  assign exp_ones = (exp_f == EXP_MAX);
  assign exp_zero = (exp_f == '0);
  assign man_zero = (man_f == '0);

  assign is_zero = exp_zero && man_zero;
  assign is_sub  = exp_zero && !man_zero;   // Denormal
  assign is_norm = !exp_zero && !exp_ones;
  assign is_inf  = exp_ones && man_zero;
  assign is_nan  = exp_ones && !man_zero;
  assign is_snan = is_nan && !man_f[QNAN_BIT];  // Quiet bit clear

  // FCLASS mask, sign ignored for NaNs
  always_comb begin
    class_mask               = '0;
    class_mask[CLS_NEG_INF]  = sign && is_inf;
    class_mask[CLS_NEG_NORM] = sign && is_norm;
    class_mask[CLS_NEG_SUB]  = sign && is_sub;
    class_mask[CLS_NEG_ZERO] = sign && is_zero;
    class_mask[CLS_POS_ZERO] = !sign && is_zero;
    class_mask[CLS_POS_SUB]  = !sign && is_sub;
    class_mask[CLS_POS_NORM] = !sign && is_norm;
    class_mask[CLS_POS_INF]  = !sign && is_inf;
    class_mask[CLS_SNAN]     = is_snan;
    class_mask[CLS_QNAN]     = is_nan && !is_snan;
  end

  // Exactly one class for any known value
  always_comb begin
    if (!$isunknown(value)) begin
      a_class_onehot: assert ($onehot(class_mask))
        else $error("class mask %b not one-hot", class_mask);
    end
  end

endmodule

// File: design/fpu_decode.sv
// ==============================
// Decode stage of the FPU pipeline
// Input handshake, funct3 decode, operand register
// ==============================

`timescale 1ns/1ns

module fpu_decode import fpu_pkg::*; (
  input  logic             clk,
  input  logic             arst_n,
  input  logic             in_valid,
  output logic             in_ready,
  input  fpu_op_e          op,
  input  logic [2:0]       funct3,
  input  logic [FLEN-1:0]  operand_a,
  input  logic [FLEN-1:0]  operand_b,
  input  logic [XLEN-1:0]  int_operand,
  input  logic             dec_advance,   // Result stage takes the decode register
  output logic             dec_valid,
  output fpu_op_e          dec_op,
  output cmp_e             dec_cmp,
  output logic [FLEN-1:0]  dec_a,
  output logic [FLEN-1:0]  dec_b,
  output logic [XLEN-1:0]  dec_int
);

  cmp_e cmp_next;
  logic accept;

  assign in_ready = !dec_valid || dec_advance;  // Empty, or draining this cycle
  assign accept   = in_valid && in_ready;

  // Compare kind from funct3, unused codes fall back to FEQ
  always_comb begin
    case (funct3)
      3'b010:  cmp_next = FEQ;
      3'b001:  cmp_next = FLT;
      3'b000:  cmp_next = FLE;
      default: cmp_next = FEQ;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      dec_valid <= 1'b0;
    end else if (accept) begin
      dec_valid <= 1'b1;
    end else if (dec_advance) begin
      dec_valid <= 1'b0;  // Drained, nothing new
    end
  end

  // Payload, no reset
  always_ff @(posedge clk) begin
    if (accept) begin
      dec_op  <= op;
      dec_cmp <= cmp_next;
      dec_a   <= operand_a;
      dec_b   <= operand_b;
      dec_int <= int_operand;
    end
  end

  // ==============================
  // Producer rules
  // ==============================
  a_legal_op: assert property (@(posedge clk) disable iff (!arst_n)
    in_valid |-> op inside {FP_SGNJ, FP_SGNJN, FP_SGNJX, FP_MIN, FP_MAX,
                            FP_CMP, FP_CLASS, FP_MV_XW, FP_MV_WX})
    else $error("illegal op %0d offered", op);

  a_in_stable: assert property (@(posedge clk) disable iff (!arst_n)
    in_valid && !in_ready |=> in_valid && $stable(op) && $stable(funct3) &&
      $stable(operand_a) && $stable(operand_b) && $stable(int_operand))
    else $error("input changed while stalled");

endmodule

// File: design/fpu_execute.sv
// ==============================
// Execute stage of the FPU pipeline
// Sign injection, FMIN/FMAX, FEQ/FLT/FLE
// FCLASS and the two bit moves
// ==============================

`timescale 1ns/1ns

module fpu_execute import fpu_pkg::*; (
  input  fpu_op_e          dec_op,
  input  cmp_e             dec_cmp,
  input  logic [FLEN-1:0]  dec_a,
  input  logic [FLEN-1:0]  dec_b,
  input  logic [XLEN-1:0]  dec_int,
  output logic [FLEN-1:0]  ex_fp_result,
  output logic [XLEN-1:0]  ex_int_result,
  output logic             ex_nv
);

  // Class facts of both operands
  logic               a_sign, a_zero, a_nan, a_snan;
  logic               b_sign, b_zero, b_nan, b_snan;
  logic [CLASS_W-1:0] a_class;

  // Ordering helpers
  logic [FLEN-2:0] a_mag;
  logic [FLEN-2:0] b_mag;
  logic            bits_lt;    // a below b, -0 below +0
  logic            both_zero;
  logic            fp_lt;      // IEEE less-than, zeros equal
  logic            fp_eq;
  logic            any_nan;
  logic            any_snan;

  // Per-unit results
  logic [FLEN-1:0] sgn_res;
  logic [FLEN-1:0] minmax_res;
  logic            cmp_true;
  logic            cmp_nv;
  logic            inj_sign;

  fpu_classify u_class_a (
    .value      (dec_a),
    .sign       (a_sign),
    .is_zero    (a_zero),
    .is_sub     (),
    .is_norm    (),
    .is_inf     (),
    .is_nan     (a_nan),
    .is_snan    (a_snan),
    .class_mask (a_class)
  );

  fpu_classify u_class_b (
    .value      (dec_b),
    .sign       (b_sign),
    .is_zero    (b_zero),
    .is_sub     (),
    .is_norm    (),
    .is_inf     (),
    .is_nan     (b_nan),
    .is_snan    (b_snan),
    .class_mask ()
  );

  // ==============================
  // Sign injection
  // ==============================
  always_comb begin
    case (dec_op)
      FP_SGNJN: inj_sign = !b_sign;
      FP_SGNJX: inj_sign = a_sign ^ b_sign;
      default:  inj_sign = b_sign;  // FSGNJ
    endcase
  end

  assign sgn_res = {inj_sign, dec_a[SIGN_BIT-1:0]};  // Keep a's exponent and mantissa

  // ==============================
  // Ordering, sign-magnitude
  // ==============================
  assign a_mag     = dec_a[SIGN_BIT-1:0];
  assign b_mag     = dec_b[SIGN_BIT-1:0];
  assign both_zero = a_zero && b_zero;
  assign any_nan   = a_nan || b_nan;
  assign any_snan  = a_snan || b_snan;

  // Negative magnitudes order in reverse
  assign bits_lt = (a_sign != b_sign) ? a_sign :
                   a_sign             ? (a_mag > b_mag) : (a_mag < b_mag);
  assign fp_lt   = bits_lt && !both_zero;
  assign fp_eq   = (dec_a == dec_b) || both_zero;  // +0 equals -0

  // Min/max, a lone NaN loses to the number
  always_comb begin
    if (a_nan && b_nan)          minmax_res = CANON_NAN;
    else if (a_nan)              minmax_res = dec_b;
    else if (b_nan)              minmax_res = dec_a;
    else if (dec_op == FP_MAX)   minmax_res = bits_lt ? dec_b : dec_a;
    else                         minmax_res = bits_lt ? dec_a : dec_b;
  end

  // Compare, unordered gives 0
  always_comb begin
    case (dec_cmp)
      FLT: begin
        cmp_true = !any_nan && fp_lt;
        cmp_nv   = any_nan;  // Signaling compare
      end
      FLE: begin
        cmp_true = !any_nan && (fp_lt || fp_eq);
        cmp_nv   = any_nan;
      end
      default: begin         // FEQ, quiet compare
        cmp_true = !any_nan && fp_eq;
        cmp_nv   = any_snan;
      end
    endcase
  end

  // ==============================
  // Result select
  // ==============================
  always_comb begin
    ex_fp_result  = '0;  // Unwritten outputs stay zero
    ex_int_result = '0;
    ex_nv         = 1'b0;
    case (dec_op)
      FP_SGNJ, FP_SGNJN, FP_SGNJX: ex_fp_result = sgn_res;
      FP_MIN, FP_MAX: begin
        ex_fp_result = minmax_res;
        ex_nv        = any_snan;
      end
      FP_CMP: begin
        ex_int_result = {{(XLEN-1){1'b0}}, cmp_true};
        ex_nv         = cmp_nv;
      end
      FP_CLASS: ex_int_result = {{(XLEN-CLASS_W){1'b0}}, a_class};
      FP_MV_XW: ex_int_result = dec_a;    // Raw bits
      FP_MV_WX: ex_fp_result  = dec_int;
      default: ;
    endcase
  end

endmodule

// File: design/fpu_pkg.sv
// ==============================
// Shared definitions for the single-cycle FPU
// Widths, float field positions, canonical NaN
// FCLASS bit positions, operation and compare enums
// ==============================

package fpu_pkg;

  // ==============================
  // Widths
  // ==============================
  localparam int FLEN  = 32;  // Float operand width
  localparam int XLEN  = 32;  // Integer operand / result width
  localparam int EXP_W = 8;   // Exponent field
  localparam int MAN_W = 23;  // Mantissa field

  // Field positions of a single-precision value
  localparam int SIGN_BIT = 31;
  localparam int QNAN_BIT = 22;  // Set on a quiet NaN

  localparam logic [EXP_W-1:0] EXP_MAX   = 8'd255;         // Inf / NaN exponent
  localparam logic [FLEN-1:0]  CANON_NAN = 32'h7FC0_0000;  // Canonical quiet NaN

  // ==============================
  // FCLASS mask
  // ==============================
  localparam int CLASS_W = 10;

  localparam int CLS_NEG_INF  = 0;
  localparam int CLS_NEG_NORM = 1;
  localparam int CLS_NEG_SUB  = 2;
  localparam int CLS_NEG_ZERO = 3;
  localparam int CLS_POS_ZERO = 4;
  localparam int CLS_POS_SUB  = 5;
  localparam int CLS_POS_NORM = 6;
  localparam int CLS_POS_INF  = 7;
  localparam int CLS_SNAN     = 8;
  localparam int CLS_QNAN     = 9;

  // ==============================
  // Operation codes
  // ==============================
  // Codes match the full FPU control encoding
  typedef enum logic [4:0] {
    FP_SGNJ  = 5'd5,
    FP_SGNJN = 5'd6,
    FP_SGNJX = 5'd7,
    FP_MIN   = 5'd8,
    FP_MAX   = 5'd9,
    FP_CMP   = 5'd11,
    FP_CLASS = 5'd12,
    FP_MV_XW = 5'd17,  // Float bits to integer
    FP_MV_WX = 5'd18   // Integer bits to float
  } fpu_op_e;

  // Compare kind, decoded from funct3
  typedef enum logic [1:0] {
    FEQ = 2'd0,
    FLT = 2'd1,
    FLE = 2'd2
  } cmp_e;

endpackage

// File: design/fpu_result.sv
// ==============================
// Result stage of the FPU pipeline
// Output register and consumer handshake
// ==============================

`timescale 1ns/1ns

module fpu_result import fpu_pkg::*; (
  input  logic             clk,
  input  logic             arst_n,
  input  logic             dec_valid,
  input  logic [FLEN-1:0]  ex_fp_result,
  input  logic [XLEN-1:0]  ex_int_result,
  input  logic             ex_nv,
  input  logic             out_ready,
  output logic             dec_advance,  // Result register loads this cycle
  output logic             out_valid,
  output logic [FLEN-1:0]  fp_result,
  output logic [XLEN-1:0]  int_result,
  output logic             flag_nv
);

  // Load when empty or the consumer takes the current result
  assign dec_advance = dec_valid && (!out_valid || out_ready);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
    end else if (dec_advance) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;  // Delivered, nothing behind it
    end
  end

  always_ff @(posedge clk) begin
    if (dec_advance) begin
      fp_result  <= ex_fp_result;
      int_result <= ex_int_result;
      flag_nv    <= ex_nv;
    end
  end

  // Held result must not change under back-pressure
  a_out_hold: assert property (@(posedge clk) disable iff (!arst_n)
    out_valid && !out_ready |=> out_valid && $stable(fp_result) &&
      $stable(int_result) && $stable(flag_nv))
    else $error("result changed while stalled");

endmodule

// File: design/fpu_top.sv
// ==============================
// FPU top level
// Decode, execute and result stages
// ==============================

`timescale 1ns/1ns

module fpu_top import fpu_pkg::*; (
  input  logic             clk,
  input  logic             arst_n,
  input  logic             in_valid,
  output logic             in_ready,
  input  fpu_op_e          op,
  input  logic [2:0]       funct3,
  input  logic [FLEN-1:0]  operand_a,
  input  logic [FLEN-1:0]  operand_b,
  input  logic [XLEN-1:0]  int_operand,
  output logic             out_valid,
  input  logic             out_ready,
  output logic [FLEN-1:0]  fp_result,
  output logic [XLEN-1:0]  int_result,
  output logic             flag_nv
);

  // Decode register
  logic            dec_valid;
  fpu_op_e         dec_op;
  cmp_e            dec_cmp;
  logic [FLEN-1:0] dec_a;
  logic [FLEN-1:0] dec_b;
  logic [XLEN-1:0] dec_int;
  logic            dec_advance;

  // Execute outputs
  logic [FLEN-1:0] ex_fp_result;
  logic [XLEN-1:0] ex_int_result;
  logic            ex_nv;

  fpu_decode u_decode (
    .clk         (clk),
    .arst_n      (arst_n),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .op          (op),
    .funct3      (funct3),
    .operand_a   (operand_a),
    .operand_b   (operand_b),
    .int_operand (int_operand),
    .dec_advance (dec_advance),
    .dec_valid   (dec_valid),
    .dec_op      (dec_op),
    .dec_cmp     (dec_cmp),
    .dec_a       (dec_a),
    .dec_b       (dec_b),
    .dec_int     (dec_int)
  );

  fpu_execute u_execute (
    .dec_op        (dec_op),
    .dec_cmp       (dec_cmp),
    .dec_a         (dec_a),
    .dec_b         (dec_b),
    .dec_int       (dec_int),
    .ex_fp_result  (ex_fp_result),
    .ex_int_result (ex_int_result),
    .ex_nv         (ex_nv)
  );

  fpu_result u_result (
    .clk           (clk),
    .arst_n        (arst_n),
    .dec_valid     (dec_valid),
    .ex_fp_result  (ex_fp_result),
    .ex_int_result (ex_int_result),
    .ex_nv         (ex_nv),
    .out_ready     (out_ready),
    .dec_advance   (dec_advance),
    .out_valid     (out_valid),
    .fp_result     (fp_result),
    .int_result    (int_result),
    .flag_nv       (flag_nv)
  );

endmodule

// File: fpu_top.f
design/fpu_pkg.sv
design/fpu_classify.sv
design/fpu_decode.sv
design/fpu_execute.sv
design/fpu_result.sv
design/fpu_top.sv
tb/fpu_checker.sv
tb/fpu_tb.sv

// File: run.sh
#!/bin/sh
# Build the FPU testbench with Verilator, run it, then scan the log for the fail line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module fpu_tb -f fpu_top.f -o fpu_sim \
  > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/fpu_sim > sim.log 2>&1 || echo "SOME TESTS FAILED" >> sim.log
cat sim.log

grep -q "SOME TESTS FAILED" sim.log && { echo "Simulation failed"; exit 1; } || exit 0

// File: tb/fpu_checker.sv
// ==============================
// FPU testbench checker
// Reference model, expected-result queues
// Comparison at the output handshake
// ==============================

`timescale 1ns/1ns

module fpu_checker import fpu_pkg::*; (
  input  logic            clk,
  input  logic            arst_n,
  input  logic            in_valid,
  input  logic            in_ready,
  input  fpu_op_e         op,
  input  logic [2:0]      funct3,
  input  logic [FLEN-1:0] operand_a,
  input  logic [FLEN-1:0] operand_b,
  input  logic [XLEN-1:0] int_operand,
  input  logic            out_valid,
  input  logic            out_ready,
  input  logic [FLEN-1:0] fp_result,
  input  logic [XLEN-1:0] int_result,
  input  logic            flag_nv,
  input  logic            finish_check,  // End of stimulus, check for leftovers
  output int              errors,
  output int              pending
);

  fpu_op_e         q_op[$];   // Pending operations, oldest first
  logic [FLEN-1:0] q_a[$];
  logic [FLEN-1:0] q_fp[$];
  logic [XLEN-1:0] q_int[$];
  logic            q_nv[$];
  int   err_count = 0;
  int   open_ops  = 0;
  logic reset_seen = 1'b0;
  logic end_done   = 1'b0;

  assign errors  = err_count;
  assign pending = open_ops;

  // Total order on the raw bits, -0 just below +0
  function automatic logic [31:0] order_key(input logic [31:0] x);
    return x[31] ? ~x : {1'b1, x[30:0]};
  endfunction

  function automatic logic nan_of(input logic [31:0] x);
    return (x[30:23] == 8'hFF) && (x[22:0] != '0);
  endfunction

  function automatic logic snan_of(input logic [31:0] x);
    return nan_of(x) && !x[22];  // Quiet bit clear
  endfunction

  function automatic logic [9:0] class_of(input logic [31:0] x);
    int idx;
    if (nan_of(x))               idx = x[22] ? CLS_QNAN : CLS_SNAN;
    else if (x[30:23] == 8'hFF)  idx = x[31] ? CLS_NEG_INF : CLS_POS_INF;
    else if (x[30:23] != 8'h00)  idx = x[31] ? CLS_NEG_NORM : CLS_POS_NORM;
    else if (x[22:0] != '0)      idx = x[31] ? CLS_NEG_SUB : CLS_POS_SUB;
    else                         idx = x[31] ? CLS_NEG_ZERO : CLS_POS_ZERO;
    return 10'(1) << idx;
  endfunction

  // ==============================
  // Reference model
  // ==============================
  task automatic model(input fpu_op_e o, input logic [2:0] f3,
                       input logic [31:0] a, input logic [31:0] b, input logic [31:0] i,
                       output logic [31:0] fp, output logic [31:0] ir, output logic nv);
    logic nan_any;
    logic snan_any;
    logic zeros;
    logic lt;
    logic eq;
    nan_any  = nan_of(a) || nan_of(b);
    snan_any = snan_of(a) || snan_of(b);
    zeros    = (a[30:0] == '0) && (b[30:0] == '0);
    lt       = !zeros && (order_key(a) < order_key(b));  // Zeros compare equal
    eq       = zeros || (a == b);
    fp = '0;
    ir = '0;
    nv = 1'b0;
    case (o)
      FP_SGNJ:  fp = {b[31], a[30:0]};
      FP_SGNJN: fp = {!b[31], a[30:0]};
      FP_SGNJX: fp = {a[31] ^ b[31], a[30:0]};
      FP_MIN, FP_MAX: begin
        nv = snan_any;
        if (nan_of(a) && nan_of(b))  fp = CANON_NAN;
        else if (nan_of(a))          fp = b;  // Lone NaN loses
        else if (nan_of(b))          fp = a;
        else if ((order_key(a) < order_key(b)) == (o == FP_MIN)) fp = a;
        else                         fp = b;
      end
      FP_CMP: begin
        case (f3)
          3'b001: begin       // FLT
            ir[0] = !nan_any && lt;
            nv    = nan_any;
          end
          3'b000: begin       // FLE
            ir[0] = !nan_any && (lt || eq);
            nv    = nan_any;
          end
          default: begin      // FEQ and unused codes
            ir[0] = !nan_any && eq;
            nv    = snan_any;
          end
        endcase
      end
      FP_CLASS: ir = {22'd0, class_of(a)};
      FP_MV_XW: ir = a;
      FP_MV_WX: fp = i;
      default: ;
    endcase
  endtask

  // ==============================
  // Handshake monitor
  // ==============================
  // Sampled mid-cycle, values here hold through the next rising edge
  always @(negedge clk) begin : monitor
    fpu_op_e     p_op;
    logic [31:0] p_a;
    logic [31:0] e_fp;
    logic [31:0] e_int;
    logic        e_nv;
    if (arst_n) begin
      if (!reset_seen) begin
        reset_seen = 1'b1;
        if (out_valid !== 1'b0 || in_ready !== 1'b1) begin
          err_count++;
          $display("Error: out_valid not low or in_ready not high after reset");
        end
      end
      // Pop before push, a result never leaves in its own accept cycle
      if (out_valid && out_ready) begin
        if (q_op.size() == 0) begin
          err_count++;
          $display("Error: result delivered with no operation pending at %0t", $time);
        end else begin
          p_op  = q_op.pop_front();
          p_a   = q_a.pop_front();
          e_fp  = q_fp.pop_front();
          e_int = q_int.pop_front();
          e_nv  = q_nv.pop_front();
          if (fp_result !== e_fp || int_result !== e_int || flag_nv !== e_nv) begin
            err_count++;
            $display("MISMATCH %0t: op %s a=%h got fp=%h int=%h nv=%b, expected %h %h %b",
                     $time, p_op.name(), p_a, fp_result, int_result, flag_nv,
                     e_fp, e_int, e_nv);
          end
        end
      end
      if (in_valid && in_ready) begin
        model(op, funct3, operand_a, operand_b, int_operand, e_fp, e_int, e_nv);
        q_op.push_back(op);
        q_a.push_back(operand_a);
        q_fp.push_back(e_fp);
        q_int.push_back(e_int);
        q_nv.push_back(e_nv);
      end
      open_ops = q_op.size();
      if (finish_check && !end_done) begin
        end_done = 1'b1;
        if (q_op.size() != 0) begin
          err_count += q_op.size();
          $display("Error: %0d operations never produced a result", q_op.size());
        end
      end
    end
  end

endmodule

// File: tb/fpu_tb.sv
// ==============================
// FPU testbench top
// Clock, reset, LFSR stimulus, DUT and checker
// Watchdog and closing report
// ==============================

`timescale 1ns/1ns

module fpu_tb import fpu_pkg::*; ();

  localparam int      CLK_PERIOD   = 8;
  localparam int      N_OPS        = 2000;
  localparam int      SEED         = 28;
  localparam int      DRAIN_CYCLES = 16;  // Well past the two-deep pipeline
  localparam longint  WATCHDOG_NS  = longint'(N_OPS) * 8 * CLK_PERIOD;

  logic            clk = 1'b0;
  logic            arst_n;
  logic            in_valid;
  logic            in_ready;
  fpu_op_e         op;
  logic [2:0]      funct3;
  logic [FLEN-1:0] operand_a;
  logic [FLEN-1:0] operand_b;
  logic [XLEN-1:0] int_operand;
  logic            out_valid;
  logic            out_ready;
  logic [FLEN-1:0] fp_result;
  logic [XLEN-1:0] int_result;
  logic            flag_nv;
  logic            finish_check;
  int              errors;
  int              pending;
  logic [31:0]     lfsr;

  always #(CLK_PERIOD/2) clk = ~clk;

  fpu_top dut_i (.*);

  fpu_checker check_i (.*);

  // ==============================
  // Random source
  // ==============================
  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] val);
    val = '0;
    repeat (n) begin
      lfsr = lfsr_next(lfsr);
      val  = {val[30:0], lfsr[0]};  // One step per bit
    end
  endtask

  function automatic fpu_op_e op_at(input int idx);
    case (idx)
      0:       return FP_SGNJ;
      1:       return FP_SGNJN;
      2:       return FP_SGNJX;
      3:       return FP_MIN;
      4:       return FP_MAX;
      5:       return FP_CMP;
      6:       return FP_CLASS;
      7:       return FP_MV_XW;
      default: return FP_MV_WX;
    endcase
  endfunction

  // Exponent all ones or all zeros half the time, gives inf, NaN, zero, subnormal
  task automatic make_operand(output logic [31:0] v);
    logic [31:0] raw;
    logic [31:0] mode;
    draw_bits(32, raw);
    draw_bits(3, mode);
    if (mode[1:0] == 2'd1)      raw[30:23] = 8'hFF;
    else if (mode[1:0] == 2'd2) raw[30:23] = 8'h00;
    if (mode[2])                raw[22:0]  = '0;  // Exact zero or inf
    v = raw;
  endtask

  // ==============================
  // Stimulus
  // ==============================
  initial begin : stimulus
    int          sent;
    int          drain;
    logic        offering;
    logic        taken;
    logic [31:0] r;
    logic [31:0] a;
    logic [31:0] b;
    lfsr         = SEED;
    arst_n       = 1'b0;
    in_valid     = 1'b0;
    op           = FP_SGNJ;
    funct3       = 3'd0;
    operand_a    = '0;
    operand_b    = '0;
    int_operand  = '0;
    out_ready    = 1'b0;
    finish_check = 1'b0;
    sent         = 0;
    offering     = 1'b0;
    taken        = 1'b0;
    repeat (4) @(posedge clk);
    arst_n <= 1'b1;
    @(posedge clk);
    while (sent < N_OPS) begin
      if (!offering || taken) begin  // Offer held until accepted
        draw_bits(2, r);
        offering = (r[1:0] != 2'd0);
        if (offering) begin
          draw_bits(4, r);
          op <= op_at(int'(r[3:0]) % 9);
          draw_bits(3, r);
          funct3 <= r[2:0];             // Unused codes too
          make_operand(a);
          make_operand(b);
          draw_bits(2, r);
          if (r[1:0] == 2'd0) b = {b[31], a[30:0]};  // Same magnitude pair
          operand_a <= a;
          operand_b <= b;
          draw_bits(32, r);
          int_operand <= r;
        end
        in_valid <= offering;
      end
      draw_bits(2, r);
      out_ready <= (r[1:0] != 2'd0);  // Back-pressure a quarter of the time
      @(negedge clk);
      taken = offering && in_ready;
      if (taken) sent++;
      @(posedge clk);
    end
    in_valid  <= 1'b0;
    out_ready <= 1'b1;
    // Drain the tail, anything left after this is a lost result
    for (drain = 0; drain < DRAIN_CYCLES && pending != 0; drain++) @(posedge clk);
    finish_check <= 1'b1;
    repeat (2) @(posedge clk);
    $display("Operations: %0d, errors: %0d", sent, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule
